// File: verification/ipod_player_testdata.txt
# flash mem <word address> <word>, all numbers hex
# <test> <cmd|speed|samples|quiet|period> <code, speed kind or period> <count>
flash mem 0 01aa02bb
flash mem 1 83cc84dd
flash mem 2 05ee86ff
flash mem 3 7f008011
flash mem 7fffe 9012a134
flash mem 7ffff c056d078
fwd_play quiet 0 1
fwd_play cmd 45 1
fwd_play samples 0 6
speed_rate period 8dc 0
stop_resume cmd 44 1
stop_resume quiet 0 3
stop_resume cmd 45 1
stop_resume samples 0 2
unknown_code cmd 5a 1
unknown_code samples 0 2
restart_fwd cmd 52 1
back_wrap cmd 42 1
back_wrap samples 0 5
restart_back cmd 52 1
restart_back samples 0 2
speed_rate speed 1 2
speed_rate period 89c 0
speed_rate speed 2 1
speed_rate period 8bc 0
speed_rate speed 1 50
speed_rate period 40 0
speed_rate speed 3 1
speed_rate period 8dc 0
unknown_code cmd 44 1
unknown_code cmd 5a 1
unknown_code quiet 0 2

// File: ipod_player.f
+incdir+src
src/ipod_data_pkg.sv
src/ipod_ctrl_pkg.sv
src/player_command_decoder.sv
src/sample_rate_divider.sv
src/flash_read_master.sv
src/sample_address_sequencer.sv
src/ipod_player_top.sv
verification/ipod_player_props.sv
verification/ipod_player_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f ipod_player.f \
		--top-module ipod_player_tb -o ipod_player_sim
	./obj_dir/ipod_player_sim

clean:
	rm -rf obj_dir

// File: verification/ipod_player_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "ipod_cfg.svh"

module ipod_player_tb;

  localparam int last_word = `IPOD_LAST_WORD;

  logic        CLK_50M = 1'b0;
  logic        reset = 1'b1;
  logic        cmd_strobe = 1'b0;
  logic [7:0]  cmd_code = 8'h00;
  logic        speed_up = 1'b0;
  logic        speed_down = 1'b0;
  logic        speed_reset = 1'b0;
  logic        flash_read;
  logic [22:0] flash_address;
  logic        flash_waitrequest = 1'b1;
  logic [31:0] flash_readdata = '0;
  logic        flash_readdatavalid = 1'b0;
  logic        sample_strobe;
  logic [7:0]  audio_sample;

  logic [31:0] flash_mem [int];
  int unsigned lcg_state = 26399;

  // Script steps
  string       step_name [$];
  string       step_kind [$];
  logic [31:0] step_arg [$];
  logic [31:0] step_cnt [$];

  // Reference position, direction and period
  int   m_addr = 0;
  logic m_half = 1'b0;
  logic m_dir = 1'b0;
  int   m_period = `IPOD_PERIOD_DEFAULT;

  ipod_player_top ipod_player_top_i (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .cmd_strobe          (cmd_strobe),
    .cmd_code            (cmd_code),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_strobe       (sample_strobe),
    .audio_sample        (audio_sample)
  );

  always #10 CLK_50M = ~CLK_50M;

  function automatic int unsigned next_random(input int unsigned range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % range;
  endfunction

  // Words outside the file get a pattern from the full address
  function automatic logic [31:0] flash_word(input int addr);
    if (flash_mem.exists(addr))
      return flash_mem[addr];
    return (32'(addr) * 32'h0001_0003) ^ 32'hc3a5_5a3c;
  endfunction

  task automatic compare(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s expected %0h actual %0h", test, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // Expected sample from the position, then step the position
  task automatic check_sample(input string test);
    logic [31:0] w;
    w = flash_word(m_addr);
    compare(test, m_half ? w[31:24] : w[15:8], 32'(audio_sample));
    if (m_half == m_dir)
      m_half = !m_half;
    else
    begin
      if (!m_dir)
        m_addr = (m_addr == last_word) ? 0 : m_addr + 1;
      else
        m_addr = (m_addr == 0) ? last_word : m_addr - 1;
      m_half = m_dir;
    end
  endtask

  task automatic next_cycle(input string test, output logic seen);
    @(posedge CLK_50M);
    seen = sample_strobe;
    if (seen)
      check_sample(test);
  endtask

  task automatic wait_sample(input string test, output int cycles);
    logic seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen)
    begin
      if (cycles >= 4 * `IPOD_PERIOD_MAX)
      begin
        $display("No sample arrived in %s before the timeout", test);
        $display("tests failed");
        $fatal(1);
      end
      next_cycle(test, seen);
      cycles++;
    end
  endtask

  // A sample seen one edge after the strobe still comes from the old state
  task automatic send_command(input string test, input logic [7:0] code);
    logic seen;
    #1;
    cmd_strobe = 1'b1;
    cmd_code = code;
    next_cycle(test, seen);
    #1 cmd_strobe = 1'b0;
    next_cycle(test, seen);
    case (code)
      8'h46: m_dir = 1'b0;
      8'h42: m_dir = 1'b1;
      8'h52:
      begin
        m_addr = m_dir ? last_word : 0;
        m_half = m_dir;
      end
      default: ;
    endcase
  endtask

  // Kind 1 speeds up, 2 slows down, 3 restores the default
  task automatic send_speed(input string test, input int kind, input int count);
    logic seen;
    repeat (count)
    begin
      #1;
      speed_up = (kind == 1);
      speed_down = (kind == 2);
      speed_reset = (kind == 3);
      next_cycle(test, seen);
      #1;
      speed_up = 1'b0;
      speed_down = 1'b0;
      speed_reset = 1'b0;
      next_cycle(test, seen);
      if (kind == 1)
        m_period = (m_period - `IPOD_SPEED_STEP < `IPOD_PERIOD_MIN) ?
                   `IPOD_PERIOD_MIN : m_period - `IPOD_SPEED_STEP;
      else if (kind == 2)
        m_period = (m_period + `IPOD_SPEED_STEP > `IPOD_PERIOD_MAX) ?
                   `IPOD_PERIOD_MAX : m_period + `IPOD_SPEED_STEP;
      else
        m_period = `IPOD_PERIOD_DEFAULT;
    end
  endtask

  task automatic expect_quiet(input string test, input int periods);
    repeat (periods * m_period)
    begin
      @(posedge CLK_50M);
      if (sample_strobe)
      begin
        $display("Unexpected sample while stopped in %s", test);
        $display("tests failed");
        $fatal(1);
      end
    end
  endtask

  // First interval after a speed change may be short, so skip it
  task automatic expect_period(input string test, input int expected);
    int cycles;
    wait_sample(test, cycles);
    wait_sample(test, cycles);
    wait_sample(test, cycles);
    compare(test, 32'(expected), 32'(cycles));
    compare(test, 32'(m_period), 32'(cycles));
  endtask

  task automatic load_script();
    int          fd;
    int          n;
    string       name;
    string       kind;
    logic [31:0] arg;
    logic [31:0] cnt;
    logic [8*200-1:0] line;
    fd = $fopen("verification/ipod_player_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the testdata file");
      $display("tests failed");
      $fatal(1);
    end
    while ($fscanf(fd, "%s", name) == 1)
    begin
      if (name == "#")
        n = $fgets(line, fd);
      else
      begin
        n = $fscanf(fd, "%s %h %h", kind, arg, cnt);
        if (n != 3)
        begin
          $display("Incomplete line for %s in the testdata file", name);
          $display("tests failed");
          $fatal(1);
        end
        if (kind == "mem")
          flash_mem[int'(arg)] = cnt;
        else
        begin
          step_name.push_back(name);
          step_kind.push_back(kind);
          step_arg.push_back(arg);
          step_cnt.push_back(cnt);
        end
      end
    end
    $fclose(fd);
  endtask

  // ==============================
  // Flash model
  // ==============================
  initial
  begin
    int unsigned wait_cycles;
    int unsigned data_cycles;
    int          addr;
    forever
    begin
      @(posedge CLK_50M);
      if (flash_read === 1'b1)
      begin
        addr = int'(flash_address);
        wait_cycles = next_random(7);
        data_cycles = next_random(4) + 1;
        repeat (wait_cycles) @(posedge CLK_50M);
        #1 flash_waitrequest = 1'b0;
        @(posedge CLK_50M);
        #1 flash_waitrequest = 1'b1;
        repeat (data_cycles - 1) @(posedge CLK_50M);
        #1;
        flash_readdatavalid = 1'b1;
        flash_readdata = flash_word(addr);
        @(posedge CLK_50M);
        #1 flash_readdatavalid = 1'b0;
      end
    end
  end

  // ==============================
  // Script runner
  // ==============================
  initial
  begin
    int cycles;
    load_script();
    repeat (2) @(posedge CLK_50M);
    #1 reset = 1'b0;
    foreach (step_kind[i])
    begin
      if (step_kind[i] == "cmd")
        send_command(step_name[i], step_arg[i][7:0]);
      else if (step_kind[i] == "speed")
        send_speed(step_name[i], int'(step_arg[i]), int'(step_cnt[i]));
      else if (step_kind[i] == "quiet")
        expect_quiet(step_name[i], int'(step_cnt[i]));
      else if (step_kind[i] == "period")
        expect_period(step_name[i], int'(step_arg[i]));
      else if (step_kind[i] == "samples")
        repeat (step_cnt[i]) wait_sample(step_name[i], cycles);
      else
      begin
        $display("Unknown step kind %s in the testdata file", step_kind[i]);
        $display("tests failed");
        $fatal(1);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/ipod_player_props.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_player_props (
  input wire logic                       CLK_50M,
  input wire logic                       reset,
  input wire logic                       flash_read,
  input wire ipod_data_pkg::flash_addr_t flash_address,
  input wire logic                       flash_waitrequest,
  input wire logic                       flash_readdatavalid,
  input wire logic                       sample_strobe
);

  // Set on acceptance, cleared when the data comes back
  logic outstanding;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      outstanding <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      outstanding <= 1'b1;
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  request_held: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("flash request changed while wait-request was high");

  read_low_after_reset: assert property (@(posedge CLK_50M) reset |=> !flash_read)
    else $error("flash_read high after reset");

  strobe_single: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_strobe |=> !sample_strobe)
    else $error("sample_strobe high for two cycles");

  one_read_outstanding: assert property (@(posedge CLK_50M) disable iff (reset)
    outstanding |-> !flash_read)
    else $error("new flash read while one is outstanding");

endmodule

bind ipod_player_top ipod_player_props ipod_player_props_i (
  .CLK_50M             (CLK_50M),
  .reset               (reset),
  .flash_read          (flash_read),
  .flash_address       (flash_address),
  .flash_waitrequest   (flash_waitrequest),
  .flash_readdatavalid (flash_readdatavalid),
  .sample_strobe       (sample_strobe)
);

`default_nettype wire

// File: src/ipod_player_top.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_player_top (
  input  logic                         CLK_50M,
  input  logic                         reset,
  input  logic                         cmd_strobe,
  input  ipod_ctrl_pkg::ascii_code_t   cmd_code,
  input  logic                         speed_up,
  input  logic                         speed_down,
  input  logic                         speed_reset,
  output logic                         flash_read,
  output ipod_data_pkg::flash_addr_t   flash_address,
  input  logic                         flash_waitrequest,
  input  ipod_data_pkg::flash_word_t   flash_readdata,
  input  logic                         flash_readdatavalid,
  output logic                         sample_strobe,
  output ipod_data_pkg::audio_sample_t audio_sample
);

  import ipod_data_pkg::*;

  logic        playing;
  logic        backward;
  logic        restart_pulse;
  logic        sample_tick;
  logic        fetch_start;
  logic        fetch_done;
  flash_addr_t fetch_address;
  flash_word_t fetch_word;

  // ==============================
  // Control
  // ==============================
  player_command_decoder player_command_decoder_i (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .cmd_strobe    (cmd_strobe),
    .cmd_code      (cmd_code),
    .playing       (playing),
    .backward      (backward),
    .restart_pulse (restart_pulse)
  );

  sample_rate_divider sample_rate_divider_i (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .playing     (playing),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_tick (sample_tick)
  );

  // ==============================
  // Data path
  // ==============================
  sample_address_sequencer sample_address_sequencer_i (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .sample_tick   (sample_tick),
    .backward      (backward),
    .restart_pulse (restart_pulse),
    .fetch_done    (fetch_done),
    .fetch_word    (fetch_word),
    .fetch_start   (fetch_start),
    .fetch_address (fetch_address),
    .sample_strobe (sample_strobe),
    .audio_sample  (audio_sample)
  );

  flash_read_master flash_read_master_i (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .fetch_start         (fetch_start),
    .fetch_address       (fetch_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .fetch_done          (fetch_done),
    .fetch_word          (fetch_word)
  );

endmodule

`default_nettype wire

// File: src/sample_address_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

`include "ipod_cfg.svh"

module sample_address_sequencer (
  input  logic                         CLK_50M,
  input  logic                         reset,
  input  logic                         sample_tick,
  input  logic                         backward,
  input  logic                         restart_pulse,
  input  logic                         fetch_done,
  input  ipod_data_pkg::flash_word_t   fetch_word,
  output logic                         fetch_start,
  output ipod_data_pkg::flash_addr_t   fetch_address,
  output logic                         sample_strobe,
  output ipod_data_pkg::audio_sample_t audio_sample
);

  import ipod_data_pkg::*;

  localparam flash_addr_t last_word = flash_addr_t'(`IPOD_LAST_WORD);

  flash_addr_t word_addr;
  flash_addr_t next_addr;
  flash_word_t word;
  logic        half_sel;       // 0 low half next, 1 high half next
  logic        fetch_needed;
  logic        fetch_busy;
  logic        tick_pending;
  logic        emit;

  assign fetch_address = word_addr;

  // Sample only once the current word has been fetched
  assign emit = (sample_tick || tick_pending) && !fetch_needed && !fetch_busy;

  always_comb
  begin
    if (backward)
      next_addr = (word_addr == '0) ? last_word : word_addr - 1'b1;
    else
      next_addr = (word_addr == last_word) ? '0 : word_addr + 1'b1;
  end

  // ==============================
  // Position and fetch control
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      word_addr     <= '0;
      half_sel      <= 1'b0;
      fetch_needed  <= 1'b1;
      fetch_busy    <= 1'b0;
      fetch_start   <= 1'b0;
      tick_pending  <= 1'b0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      fetch_start   <= 1'b0;
      sample_strobe <= 1'b0;
      if (fetch_done)
      begin
        word       <= fetch_word;
        fetch_busy <= 1'b0;
      end
      if (fetch_needed && !fetch_busy)
      begin
        fetch_start  <= 1'b1;
        fetch_busy   <= 1'b1;
        fetch_needed <= 1'b0;
      end
      if (restart_pulse)
      begin
        word_addr    <= backward ? last_word : '0;
        half_sel     <= backward;
        fetch_needed <= 1'b1;
        tick_pending <= tick_pending || sample_tick;
      end
      else if (emit)
      begin
        sample_strobe <= 1'b1;
        audio_sample  <= half_sel ? word[31:24] : word[15:8];
        tick_pending  <= 1'b0;
        // First half of the word in this direction, then step the word
        if (half_sel == backward)
          half_sel <= !half_sel;
        else
        begin
          word_addr    <= next_addr;
          half_sel     <= backward;
          fetch_needed <= 1'b1;
        end
      end
      else if (sample_tick)
        tick_pending <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/flash_read_master.sv
`default_nettype none
`timescale 1ns/1ps

module flash_read_master (
  input  logic                       CLK_50M,
  input  logic                       reset,
  input  logic                       fetch_start,
  input  ipod_data_pkg::flash_addr_t fetch_address,
  input  logic                       flash_waitrequest,
  input  logic                       flash_readdatavalid,
  input  ipod_data_pkg::flash_word_t flash_readdata,
  output logic                       flash_read,
  output ipod_data_pkg::flash_addr_t flash_address,
  output logic                       fetch_done,
  output ipod_data_pkg::flash_word_t fetch_word
);

  import ipod_ctrl_pkg::*;

  read_state_t state;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state      <= idle;
      flash_read <= 1'b0;
      fetch_done <= 1'b0;
    end
    else
    begin
      fetch_done <= 1'b0;
      case (state)
        idle:
          if (fetch_start)
          begin
            flash_address <= fetch_address;
            flash_read    <= 1'b1;
            state         <= request;
          end
        // Address and read held until the slave drops wait-request
        request:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= wait_data;
          end
        wait_data:
          if (flash_readdatavalid)
          begin
            fetch_word <= flash_readdata;
            fetch_done <= 1'b1;
            state      <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/sample_rate_divider.sv
`default_nettype none
`timescale 1ns/1ps

`include "ipod_cfg.svh"

module sample_rate_divider (
  input  logic CLK_50M,
  input  logic reset,
  input  logic playing,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output logic sample_tick
);

  import ipod_data_pkg::*;

  localparam sample_period_t period_default = sample_period_t'(`IPOD_PERIOD_DEFAULT);
  localparam sample_period_t period_min     = sample_period_t'(`IPOD_PERIOD_MIN);
  localparam sample_period_t period_max     = sample_period_t'(`IPOD_PERIOD_MAX);
  localparam sample_period_t speed_step     = sample_period_t'(`IPOD_SPEED_STEP);

  sample_period_t period;
  sample_period_t cycle_count;

  // ==============================
  // Period register with clamping
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_reset)
      period <= period_default;
    else if (speed_up)
      period <= (period < period_min + speed_step) ? period_min : period - speed_step;
    else if (speed_down)
      period <= (period > period_max - speed_step) ? period_max : period + speed_step;
  end

  // Tick counter, parked at zero while stopped
  always_ff @(posedge CLK_50M)
  begin
    sample_tick <= 1'b0;
    if (reset || !playing)
      cycle_count <= '0;
    else if (cycle_count >= period - 1'b1)  // >= covers a period that just shrank
    begin
      cycle_count <= '0;
      sample_tick <= 1'b1;
    end
    else
      cycle_count <= cycle_count + 1'b1;
  end

endmodule

`default_nettype wire

// File: src/player_command_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module player_command_decoder (
  input  logic                      CLK_50M,
  input  logic                      reset,
  input  logic                      cmd_strobe,
  input  ipod_ctrl_pkg::ascii_code_t cmd_code,
  output logic                      playing,
  output logic                      backward,
  output logic                      restart_pulse
);

  import ipod_ctrl_pkg::*;

  play_state_t play_state;

  // The port shadows the enum literal, so the literal is named in full
  assign playing = (play_state == ipod_ctrl_pkg::playing);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play_state    <= stopped;
      backward      <= 1'b0;
      restart_pulse <= 1'b0;
    end
    else
    begin
      restart_pulse <= 1'b0;
      if (cmd_strobe)
      begin
        case (cmd_code)
          cmd_play:     play_state <= ipod_ctrl_pkg::playing;
          cmd_stop:     play_state <= stopped;
          cmd_forward:  backward <= 1'b0;
          cmd_backward: backward <= 1'b1;
          cmd_restart:  restart_pulse <= 1'b1;
          // Anything else is not a player command
          default:      play_state <= play_state;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/ipod_ctrl_pkg.sv
`default_nettype none

package ipod_ctrl_pkg;

  // ==============================
  // FSM encodings
  // ==============================
  typedef enum logic {
    stopped,
    playing
  } play_state_t;

  typedef enum logic [1:0] {
    idle,
    request,
    wait_data
  } read_state_t;

  // ==============================
  // Keyboard commands
  // ==============================
  typedef logic [7:0] ascii_code_t;

  localparam ascii_code_t cmd_play     = 8'h45;  // 'E'
  localparam ascii_code_t cmd_stop     = 8'h44;  // 'D'
  localparam ascii_code_t cmd_forward  = 8'h46;  // 'F'
  localparam ascii_code_t cmd_backward = 8'h42;  // 'B'
  localparam ascii_code_t cmd_restart  = 8'h52;  // 'R'

endpackage

`default_nettype wire

// File: src/ipod_data_pkg.sv
`default_nettype none

`include "ipod_cfg.svh"

package ipod_data_pkg;

  // Word address into the flash
  typedef logic [`IPOD_FLASH_ADDR_W-1:0] flash_addr_t;

  // One flash word, two samples inside
  typedef logic [`IPOD_FLASH_DATA_W-1:0] flash_word_t;

  typedef logic signed [`IPOD_SAMPLE_W-1:0] audio_sample_t;

  // Clock cycles between two samples
  typedef logic [`IPOD_PERIOD_W-1:0] sample_period_t;

endpackage

`default_nettype wire

// File: src/ipod_cfg.svh
`ifndef IPOD_CFG_SVH
`define IPOD_CFG_SVH

// Flash bus geometry
`define IPOD_FLASH_ADDR_W 23
`define IPOD_FLASH_DATA_W 32

// Audio data path
`define IPOD_SAMPLE_W 8
`define IPOD_PERIOD_W 16

// Song extent and playback rate, period values in clock cycles
`define IPOD_LAST_WORD 'h7FFFF
`define IPOD_PERIOD_DEFAULT 2268
`define IPOD_PERIOD_MIN 64
`define IPOD_PERIOD_MAX 8192
`define IPOD_SPEED_STEP 32

`endif
